// File: Makefile
SIM  = obj_dir/Vtb_vga_end_top
SRCS = vga_pkg.sv vga_timing.sv draw_end_bg.sv draw_end_banner.sv vga_end_top.sv \
       tb_vga_end_top.sv

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

$(SIM): all.f $(SRCS)
	verilator --binary --assert --top-module tb_vga_end_top -f all.f

clean:
	rm -rf obj_dir

// File: all.f
vga_pkg.sv
vga_timing.sv
draw_end_bg.sv
draw_end_banner.sv
vga_end_top.sv
tb_vga_end_top.sv

// File: draw_end_banner.sv
`default_nettype none

module draw_end_banner
    import vga_pkg::*;
#(
    parameter int BANNER_X = BANNER_X_DEF,
    parameter int BANNER_Y = BANNER_Y_DEF,
    parameter int BANNER_W = BANNER_W_DEF,
    parameter int BANNER_H = BANNER_H_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       game_over,
    input  logic       restart,
    input  vga_coord_t hcount_in,
    input  vga_coord_t vcount_in,
    input  logic       hsync_in,
    input  logic       vsync_in,
    input  logic       hblnk_in,
    input  logic       vblnk_in,
    input  rgb_t       rgb_in,
    output vga_coord_t hcount,
    output vga_coord_t vcount,
    output logic       hsync,
    output logic       vsync,
    output logic       hblnk,
    output logic       vblnk,
    output rgb_t       rgb
);

    localparam vga_coord_t X_BEG = vga_coord_t'(BANNER_X);
    localparam vga_coord_t Y_BEG = vga_coord_t'(BANNER_Y);
    localparam vga_coord_t X_END = vga_coord_t'(BANNER_X + BANNER_W);   // exclusive
    localparam vga_coord_t Y_END = vga_coord_t'(BANNER_Y + BANNER_H);   // exclusive

    banner_state_t state;
    banner_state_t state_nxt;
    logic          in_box;
    rgb_t          rgb_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            BANNER_OFF: if (game_over && !restart) state_nxt = BANNER_ON;
            BANNER_ON:  if (restart) state_nxt = BANNER_OFF;   // restart has priority
            default:    state_nxt = BANNER_OFF;
        endcase
    end

    always_comb begin
        in_box = (hcount_in >= X_BEG) && (hcount_in < X_END)
              && (vcount_in >= Y_BEG) && (vcount_in < Y_END);
        if ((state == BANNER_ON) && in_box && !hblnk_in && !vblnk_in) begin
            rgb_nxt = COLOR_BANNER;                   // box covers borders too
        end else begin
            rgb_nxt = rgb_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= BANNER_OFF;
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= COLOR_BLANK;
        end else begin
            state  <= state_nxt;                      // seen by next pixel out
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            rgb    <= rgb_nxt;
        end
    end

    a_strobe_excl: assert property (
        @(posedge clk) disable iff (rst) !(game_over && restart)
    ) else $warning("game_over and restart together, restart taken");

endmodule

`default_nettype wire

// File: draw_end_bg.sv
`default_nettype none

module draw_end_bg
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = H_ACTIVE_DEF,
    parameter int V_ACTIVE = V_ACTIVE_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  vga_coord_t hcount_in,
    input  vga_coord_t vcount_in,
    input  logic       hsync_in,
    input  logic       vsync_in,
    input  logic       hblnk_in,
    input  logic       vblnk_in,
    output vga_coord_t hcount,
    output vga_coord_t vcount,
    output logic       hsync,
    output logic       vsync,
    output logic       hblnk,
    output logic       vblnk,
    output rgb_t       rgb
);

    localparam vga_coord_t H_LAST = vga_coord_t'(H_ACTIVE - 1);   // rightmost column
    localparam vga_coord_t V_LAST = vga_coord_t'(V_ACTIVE - 1);   // bottom row

    rgb_t rgb_nxt;

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = COLOR_BLANK;                    // nothing drawn in porches
        end else if (vcount_in == '0) begin
            rgb_nxt = COLOR_TOP;
        end else if (vcount_in == V_LAST) begin
            rgb_nxt = COLOR_BOTTOM;
        end else if (hcount_in == '0) begin
            rgb_nxt = COLOR_LEFT;                     // corners go to top/bottom
        end else if (hcount_in == H_LAST) begin
            rgb_nxt = COLOR_RIGHT;
        end else begin
            rgb_nxt = COLOR_FILL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= COLOR_BLANK;
        end else begin
            hcount <= hcount_in;                      // bundle delayed as one
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            rgb    <= rgb_nxt;
        end
    end

    a_blank_black: assert property (
        @(posedge clk) disable iff (rst) (hblnk || vblnk) |-> (rgb == COLOR_BLANK)
    ) else $error("colour %h during blanking", rgb);

endmodule

`default_nettype wire

// File: tb_vga_end_top.sv
`default_nettype none

module tb_vga_end_top
    import vga_pkg::*;
();

    localparam int H_ACTIVE = 40;                     // tiny mode keeps frames short
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 6;
    localparam int H_BP     = 6;
    localparam int V_ACTIVE = 30;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 3;
    localparam int V_BP     = 3;
    localparam int BANNER_X = 10;
    localparam int BANNER_Y = 8;
    localparam int BANNER_W = 12;
    localparam int BANNER_H = 6;

    localparam int H_TOTAL       = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL       = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int RUN_CYCLES    = 4 * FRAME_CYCLES + 2;             // two stages to fill
    localparam int WATCHDOG_TIME = (RESET_CYCLES + 6 * FRAME_CYCLES) * CLK_PERIOD;

    logic       clk;
    logic       rst;
    logic       game_over;
    logic       restart;
    vga_coord_t hcount;
    vga_coord_t vcount;
    logic       hsync;
    logic       vsync;
    logic       hblnk;
    logic       vblnk;
    rgb_t       rgb;

    integer seed = 62748;
    int     rnd;
    int     tim_h = 0;                                // model of timing generator out
    int     tim_v = 0;
    int     frame = 0;
    int     bg_h = 0;                                 // model of background stage out
    int     bg_v = 0;
    bit     bg_valid = 1'b0;
    bit     banner_on = 1'b0;
    bit     seen_on = 1'b0;
    bit     seen_off = 1'b0;
    int     checks [5] = '{0, 0, 0, 0, 0};
    int     errors [5] = '{0, 0, 0, 0, 0};
    string  test_names [5] = '{"timing", "blanking", "borders", "fill", "banner"};

    vga_end_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .BANNER_X(BANNER_X), .BANNER_Y(BANNER_Y),
        .BANNER_W(BANNER_W), .BANNER_H(BANNER_H)
    ) dut_i (
        .clk(clk), .rst(rst), .game_over(game_over), .restart(restart),
        .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
        .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic bit inside_box(input int h, input int v);
        return (h >= BANNER_X) && (h < BANNER_X + BANNER_W)
            && (v >= BANNER_Y) && (v < BANNER_Y + BANNER_H);
    endfunction

    function automatic rgb_t pixel_color(input int h, input int v, input bit on);
        if (h >= H_ACTIVE || v >= V_ACTIVE) return COLOR_BLANK;
        if (on && inside_box(h, v)) return COLOR_BANNER;   // box wins over borders
        if (v == 0) return COLOR_TOP;
        if (v == V_ACTIVE - 1) return COLOR_BOTTOM;
        if (h == 0) return COLOR_LEFT;
        if (h == H_ACTIVE - 1) return COLOR_RIGHT;
        return COLOR_FILL;
    endfunction

    task automatic check_value(input int test, input string what, input int expected,
                               input int actual, input int h, input int v);
        checks[test]++;
        if (actual != expected) begin
            errors[test]++;
            $display("Mismatch %s: %s expected %0h actual %0h at (%0d,%0d)",
                     test_names[test], what, expected, actual, h, v);
        end
    endtask

    task automatic compare_outputs(input int h, input int v, input bit on);
        int exp_rgb;
        int test;
        exp_rgb = int'(pixel_color(h, v, on));
        check_value(0, "hcount", h, int'(hcount), h, v);
        check_value(0, "vcount", v, int'(vcount), h, v);
        check_value(0, "hblnk", int'(h >= H_ACTIVE), int'(hblnk), h, v);
        check_value(0, "vblnk", int'(v >= V_ACTIVE), int'(vblnk), h, v);
        check_value(0, "hsync", int'((h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC)),
                    int'(hsync), h, v);
        check_value(0, "vsync", int'((v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC)),
                    int'(vsync), h, v);
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            test = 1;
        end else if (inside_box(h, v)) begin
            test = 4;
            if (on) seen_on = 1'b1;
            else seen_off = 1'b1;                     // box area showing background
        end else if (v == 0 || v == V_ACTIVE - 1 || h == 0 || h == H_ACTIVE - 1) begin
            test = 2;
        end else begin
            test = 3;
        end
        check_value(test, "rgb", exp_rgb, int'(rgb), h, v);
    endtask

    // one clock edge of the model, strobes as the DUT sampled them
    task automatic advance_model;
        bg_h = tim_h;
        bg_v = tim_v;
        bg_valid = 1'b1;
        if (restart) banner_on = 1'b0;                // restart wins
        else if (game_over) banner_on = 1'b1;
        if (tim_h == H_TOTAL - 1) begin
            tim_h = 0;
            if (tim_v == V_TOTAL - 1) begin
                tim_v = 0;
                frame++;
            end else begin
                tim_v++;
            end
        end else begin
            tim_h++;
        end
    endtask

    task automatic drive_strobes;
        game_over = 1'b0;
        restart   = 1'b0;
        if (tim_h == 0 && tim_v == 0 && frame == 1) begin
            game_over = 1'b1;                         // banner up for this frame
        end else if (tim_h == 0 && tim_v == 0 && frame == 2) begin
            restart = 1'b1;                           // and down for the next
        end else if (frame == 0 || frame == 3) begin
            rnd = $random(seed);
            if ((rnd & 'h7fff_ffff) % 200 == 0) begin
                if (rnd[16]) game_over = 1'b1;
                else restart = 1'b1;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not end within six frames of clock cycles");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errors;
        total_checks = 0;
        total_errors = 0;
        rst       = 1'b1;
        game_over = 1'b0;
        restart   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value(0, "reset counters", 0, int'({hcount, vcount}), 0, 0);
        check_value(0, "reset flags and rgb", 0, int'({hsync, vsync, hblnk, vblnk, rgb}), 0, 0);
        #1;
        rst = 1'b0;
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge clk);
            #1;                                       // registers settled
            if (bg_valid) compare_outputs(bg_h, bg_v, banner_on);
            advance_model();
            #1;
            drive_strobes();
        end
        if (!seen_on) begin
            errors[4]++;
            $display("banner: the box was never drawn while the banner was on");
        end
        if (!seen_off) begin
            errors[4]++;
            $display("banner: the box area was never seen with the banner off");
        end
        for (int t = 0; t < 5; t++) begin
            $display("%s: %0d checks, %0d errors", test_names[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vga_end_top.sv
`default_nettype none

module vga_end_top
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = H_ACTIVE_DEF,
    parameter int H_FP     = H_FP_DEF,
    parameter int H_SYNC   = H_SYNC_DEF,
    parameter int H_BP     = H_BP_DEF,
    parameter int V_ACTIVE = V_ACTIVE_DEF,
    parameter int V_FP     = V_FP_DEF,
    parameter int V_SYNC   = V_SYNC_DEF,
    parameter int V_BP     = V_BP_DEF,
    parameter int BANNER_X = BANNER_X_DEF,
    parameter int BANNER_Y = BANNER_Y_DEF,
    parameter int BANNER_W = BANNER_W_DEF,
    parameter int BANNER_H = BANNER_H_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       game_over,
    input  logic       restart,
    output vga_coord_t hcount,
    output vga_coord_t vcount,
    output logic       hsync,
    output logic       vsync,
    output logic       hblnk,
    output logic       vblnk,
    output rgb_t       rgb
);

    vga_coord_t tim_hcount;                           // timing generator out
    vga_coord_t tim_vcount;
    logic       tim_hsync;
    logic       tim_vsync;
    logic       tim_hblnk;
    logic       tim_vblnk;

    vga_coord_t bg_hcount;                            // background stage out
    vga_coord_t bg_vcount;
    logic       bg_hsync;
    logic       bg_vsync;
    logic       bg_hblnk;
    logic       bg_vblnk;
    rgb_t       bg_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .clk(clk), .rst(rst),
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync),
        .hblnk(tim_hblnk), .vblnk(tim_vblnk)
    );

    draw_end_bg #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
    ) u_bg (
        .clk(clk), .rst(rst),
        .hcount_in(tim_hcount), .vcount_in(tim_vcount),
        .hsync_in(tim_hsync), .vsync_in(tim_vsync),
        .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
        .hcount(bg_hcount), .vcount(bg_vcount),
        .hsync(bg_hsync), .vsync(bg_vsync),
        .hblnk(bg_hblnk), .vblnk(bg_vblnk),
        .rgb(bg_rgb)
    );

    draw_end_banner #(
        .BANNER_X(BANNER_X), .BANNER_Y(BANNER_Y),
        .BANNER_W(BANNER_W), .BANNER_H(BANNER_H)
    ) u_banner (
        .clk(clk), .rst(rst),
        .game_over(game_over), .restart(restart),
        .hcount_in(bg_hcount), .vcount_in(bg_vcount),
        .hsync_in(bg_hsync), .vsync_in(bg_vsync),
        .hblnk_in(bg_hblnk), .vblnk_in(bg_vblnk),
        .rgb_in(bg_rgb),
        .hcount(hcount), .vcount(vcount),
        .hsync(hsync), .vsync(vsync),
        .hblnk(hblnk), .vblnk(vblnk),
        .rgb(rgb)
    );

endmodule

`default_nettype wire

// File: vga_pkg.sv
`default_nettype none

package vga_pkg;

    typedef logic [10:0] vga_coord_t;                 // pixel counter, up to 2047
    typedef logic [11:0] rgb_t;                       // 4-4-4 colour

    localparam rgb_t COLOR_BLANK  = 12'h0_0_0;        // black
    localparam rgb_t COLOR_TOP    = 12'hf_f_0;        // yellow
    localparam rgb_t COLOR_BOTTOM = 12'hf_0_0;        // red
    localparam rgb_t COLOR_LEFT   = 12'h0_f_0;        // green
    localparam rgb_t COLOR_RIGHT  = 12'h0_0_f;        // blue
    localparam rgb_t COLOR_FILL   = 12'h8_8_f;        // gray-blue
    localparam rgb_t COLOR_BANNER = 12'h8_0_0;        // dark red

    // 800x600 at 60 Hz, 40 MHz pixel clock
    localparam int H_ACTIVE_DEF = 800;
    localparam int H_FP_DEF     = 40;
    localparam int H_SYNC_DEF   = 128;
    localparam int H_BP_DEF     = 88;
    localparam int V_ACTIVE_DEF = 600;
    localparam int V_FP_DEF     = 1;
    localparam int V_SYNC_DEF   = 4;
    localparam int V_BP_DEF     = 23;

    localparam int BANNER_X_DEF = 250;                // left edge of the box
    localparam int BANNER_Y_DEF = 250;                // top edge of the box
    localparam int BANNER_W_DEF = 300;
    localparam int BANNER_H_DEF = 100;

    typedef enum logic {BANNER_OFF, BANNER_ON} banner_state_t;

endpackage

`default_nettype wire

// File: vga_timing.sv
`default_nettype none

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = H_ACTIVE_DEF,
    parameter int H_FP     = H_FP_DEF,
    parameter int H_SYNC   = H_SYNC_DEF,
    parameter int H_BP     = H_BP_DEF,
    parameter int V_ACTIVE = V_ACTIVE_DEF,
    parameter int V_FP     = V_FP_DEF,
    parameter int V_SYNC   = V_SYNC_DEF,
    parameter int V_BP     = V_BP_DEF
) (
    input  logic       clk,
    input  logic       rst,
    output vga_coord_t hcount,
    output vga_coord_t vcount,
    output logic       hsync,
    output logic       vsync,
    output logic       hblnk,
    output logic       vblnk
);

    localparam vga_coord_t H_LAST     = vga_coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
    localparam vga_coord_t V_LAST     = vga_coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
    localparam vga_coord_t H_BLNK_BEG = vga_coord_t'(H_ACTIVE);
    localparam vga_coord_t V_BLNK_BEG = vga_coord_t'(V_ACTIVE);
    localparam vga_coord_t H_SYNC_BEG = vga_coord_t'(H_ACTIVE + H_FP);
    localparam vga_coord_t V_SYNC_BEG = vga_coord_t'(V_ACTIVE + V_FP);
    localparam vga_coord_t H_SYNC_END = vga_coord_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam vga_coord_t V_SYNC_END = vga_coord_t'(V_ACTIVE + V_FP + V_SYNC);

    vga_coord_t hcount_nxt;
    vga_coord_t vcount_nxt;
    logic       hsync_nxt;
    logic       vsync_nxt;
    logic       hblnk_nxt;
    logic       vblnk_nxt;

    always_comb begin
        if (hcount == H_LAST) begin                   // end of line
            hcount_nxt = '0;
            if (vcount == V_LAST) begin               // end of frame
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end else begin
            hcount_nxt = hcount + 1'b1;
            vcount_nxt = vcount;                      // hold row mid-line
        end
    end

    // flags decoded ahead from next counts so they land with them
    always_comb begin
        hblnk_nxt = (hcount_nxt >= H_BLNK_BEG);
        vblnk_nxt = (vcount_nxt >= V_BLNK_BEG);
        hsync_nxt = (hcount_nxt >= H_SYNC_BEG) && (hcount_nxt < H_SYNC_END);
        vsync_nxt = (vcount_nxt >= V_SYNC_BEG) && (vcount_nxt < V_SYNC_END);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= hsync_nxt;
            vsync  <= vsync_nxt;
            hblnk  <= hblnk_nxt;
            vblnk  <= vblnk_nxt;
        end
    end

    // sync pulse must sit inside the porch region
    a_hsync_in_blank: assert property (
        @(posedge clk) disable iff (rst) hsync |-> hblnk
    ) else $error("hsync high during active video at hcount %0d", hcount);

endmodule

`default_nettype wire
